// ==== src/lsu_consts.svh ====
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// --------------------
// Queue geometry
// --------------------

// Number of in-flight loads and stores
`define LSU_QUEUE_DEPTH 8
// Index into the ring, log2 of the depth
`define LSU_PTR_W 3

// --------------------
// Datapath widths
// --------------------

// Tag handed out by the core, one per memory op
`define LSU_TAG_W 8
// Addresses and data words
`define LSU_WORD_W 64

`endif

// ==== src/lsu_pkg.sv ====
`include "lsu_consts.svh"

package lsu_pkg;

  typedef enum logic {
    LSU_LOAD  = 1'b0,
    LSU_STORE = 1'b1
  } lsu_op_e;

  // Announcement from the core, in program order
  typedef struct packed {
    logic                   strobe;
    logic [`LSU_TAG_W-1:0]  tag;
    lsu_op_e                op;
  } lsu_instr_t;

  // Address and store data, arrives later in any order
  typedef struct packed {
    logic                   strobe;
    logic [`LSU_TAG_W-1:0]  tag;
    logic [`LSU_WORD_W-1:0] addr;
    logic [`LSU_WORD_W-1:0] value;
  } lsu_data_t;

  // One slot of the ring
  typedef struct packed {
    logic                   valid;
    logic                   resolved;
    logic                   dispatched;
    logic                   complete;
    logic [`LSU_TAG_W-1:0]  tag;
    lsu_op_e                op;
    logic [`LSU_WORD_W-1:0] addr;
    // Store data, or the load result once forwarded
    logic [`LSU_WORD_W-1:0] value;
  } lsu_entry_t;

  // Memory request, candidate from select or the live L1D request
  typedef struct packed {
    logic                   valid;
    logic                   we;
    logic [`LSU_TAG_W-1:0]  tag;
    logic [`LSU_WORD_W-1:0] addr;
    logic [`LSU_WORD_W-1:0] value;
  } lsu_mem_req_t;

  typedef struct packed {
    logic                   strobe;
    logic [`LSU_TAG_W-1:0]  tag;
    logic                   write_complete;
    logic [`LSU_WORD_W-1:0] value;
  } lsu_mem_resp_t;

  // Completion back to the core
  typedef struct packed {
    logic                   strobe;
    logic [`LSU_TAG_W-1:0]  tag;
    logic [`LSU_WORD_W-1:0] value;
  } lsu_cpl_t;

  // Store-to-load forward
  typedef struct packed {
    logic                   valid;
    logic [`LSU_PTR_W-1:0]  idx;
    logic [`LSU_WORD_W-1:0] value;
  } lsu_fwd_t;

endpackage

// ==== src/lsu_queue.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_queue (
  input  logic                   clk_in,
  input  logic                   rst_N_in,
  input  lsu_pkg::lsu_instr_t    instr,
  input  lsu_pkg::lsu_data_t     data,
  output logic                   instr_ready,
  output lsu_pkg::lsu_entry_t    entries [`LSU_QUEUE_DEPTH],
  output logic [`LSU_PTR_W-1:0]  head,
  input  logic [`LSU_PTR_W-1:0]  cand_idx,
  input  logic                   take,
  input  lsu_pkg::lsu_fwd_t      fwd,
  input  lsu_pkg::lsu_mem_resp_t mem_resp,
  output lsu_pkg::lsu_cpl_t      cpl
);

  lsu_pkg::lsu_entry_t   q [`LSU_QUEUE_DEPTH];
  logic [`LSU_PTR_W-1:0] head_q;
  logic [`LSU_PTR_W-1:0] tail_q;
  // One extra bit so a full ring is distinct from an empty one
  logic [`LSU_PTR_W:0]   count_q;

  logic                  alloc;
  logic                  retire;
  logic                  res_hit;
  logic [`LSU_PTR_W-1:0] res_idx;
  logic                  mem_hit;
  logic [`LSU_PTR_W-1:0] mem_idx;
  logic                  done_hit;
  logic [`LSU_PTR_W-1:0] done_idx;

  assign instr_ready = (count_q != (`LSU_PTR_W+1)'(`LSU_QUEUE_DEPTH));
  assign alloc       = instr.strobe && instr_ready;
  // Head slot already freed, step over it
  assign retire      = (count_q != '0) && !q[head_q].valid;
  assign entries     = q;
  assign head        = head_q;

  // --------------------
  // Lookups
  // --------------------
  always_comb begin
    logic [`LSU_PTR_W-1:0] idx;
    res_hit  = 1'b0;
    res_idx  = '0;
    mem_hit  = 1'b0;
    mem_idx  = '0;
    done_hit = 1'b0;
    done_idx = '0;
    // Tags are unique among live entries
    for (int i = 0; i < `LSU_QUEUE_DEPTH; i++) begin
      if (q[i].valid && !q[i].resolved && (q[i].tag == data.tag)) begin
        res_hit = 1'b1;
        res_idx = (`LSU_PTR_W)'(i);
      end
      if (q[i].valid && q[i].dispatched && (q[i].tag == mem_resp.tag)) begin
        mem_hit = 1'b1;
        mem_idx = (`LSU_PTR_W)'(i);
      end
    end
    // Oldest forwarded load still waiting for the completion slot
    for (int k = 0; k < `LSU_QUEUE_DEPTH; k++) begin
      idx = head_q + (`LSU_PTR_W)'(k);
      if (!done_hit && q[idx].valid && q[idx].complete) begin
        done_hit = 1'b1;
        done_idx = idx;
      end
    end
  end

  // --------------------
  // Ring update
  // --------------------
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      head_q     <= '0;
      tail_q     <= '0;
      count_q    <= '0;
      cpl.strobe <= 1'b0;
      for (int i = 0; i < `LSU_QUEUE_DEPTH; i++) begin
        q[i].valid      <= 1'b0;
        q[i].resolved   <= 1'b0;
        q[i].dispatched <= 1'b0;
        q[i].complete   <= 1'b0;
      end
    end else begin
      cpl.strobe <= 1'b0;

      // New op at the tail, address comes later
      if (alloc) begin
        q[tail_q].valid      <= 1'b1;
        q[tail_q].resolved   <= 1'b0;
        q[tail_q].dispatched <= 1'b0;
        q[tail_q].complete   <= 1'b0;
        q[tail_q].tag        <= instr.tag;
        q[tail_q].op         <= instr.op;
        tail_q               <= tail_q + 1'b1;
      end

      // Address delivery, store data too
      if (data.strobe && res_hit) begin
        q[res_idx].resolved <= 1'b1;
        q[res_idx].addr     <= data.addr;
        if (q[res_idx].op == lsu_pkg::LSU_STORE) begin
          q[res_idx].value <= data.value;
        end
      end

      // Port latched the candidate
      if (take) begin
        q[cand_idx].dispatched <= 1'b1;
      end

      // Load satisfied from an older store
      if (fwd.valid) begin
        q[fwd.idx].value    <= fwd.value;
        q[fwd.idx].complete <= 1'b1;
      end

      // Memory response wins the completion slot
      if (mem_resp.strobe && mem_hit) begin
        cpl.strobe        <= 1'b1;
        cpl.tag           <= mem_resp.tag;
        cpl.value         <= mem_resp.write_complete ? '0 : mem_resp.value;
        q[mem_idx].valid  <= 1'b0;
      end else if (done_hit) begin
        cpl.strobe        <= 1'b1;
        cpl.tag           <= q[done_idx].tag;
        cpl.value         <= q[done_idx].value;
        q[done_idx].valid <= 1'b0;
      end

      if (retire) begin
        head_q <= head_q + 1'b1;
      end
      case ({alloc, retire})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== src/lsu_dispatch_select.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_dispatch_select (
  input  lsu_pkg::lsu_entry_t   entries [`LSU_QUEUE_DEPTH],
  input  logic [`LSU_PTR_W-1:0] head,
  output lsu_pkg::lsu_mem_req_t cand,
  output logic [`LSU_PTR_W-1:0] cand_idx,
  output lsu_pkg::lsu_fwd_t     fwd
);

  always_comb begin
    logic [`LSU_PTR_W-1:0]  idx;
    logic [`LSU_PTR_W-1:0]  ld_idx;
    logic [`LSU_PTR_W-1:0]  ld_age;
    logic [`LSU_PTR_W-1:0]  st_idx;
    logic [`LSU_PTR_W-1:0]  sel;
    logic                   st_unres;
    logic                   older_open;
    logic                   ld_ok;
    logic                   ld_first;
    logic                   st_ok;
    logic                   hit;
    logic [`LSU_WORD_W-1:0] hit_value;
    logic                   use_ld;
    logic                   use_st;

    ld_idx     = '0;
    ld_age     = '0;
    st_idx     = '0;
    st_unres   = 1'b0;
    older_open = 1'b0;
    ld_ok      = 1'b0;
    ld_first   = 1'b0;
    st_ok      = 1'b0;
    hit        = 1'b0;
    hit_value  = '0;

    // --------------------
    // Age-order walk
    // --------------------
    // Slots past the tail are never valid, so a full lap is safe
    for (int k = 0; k < `LSU_QUEUE_DEPTH; k++) begin
      idx = head + (`LSU_PTR_W)'(k);
      if (entries[idx].valid) begin
        if (entries[idx].op == lsu_pkg::LSU_LOAD) begin
          // Oldest load with every older store address known
          if (!ld_ok && entries[idx].resolved && !entries[idx].dispatched &&
              !entries[idx].complete && !st_unres) begin
            ld_ok    = 1'b1;
            ld_idx   = idx;
            ld_age   = (`LSU_PTR_W)'(k);
            ld_first = !st_ok;
          end
        end else begin
          // Stores leave strictly in order
          if (!st_ok && entries[idx].resolved && !entries[idx].dispatched &&
              !older_open) begin
            st_ok  = 1'b1;
            st_idx = idx;
          end
          if (!entries[idx].resolved) begin
            st_unres = 1'b1;
          end
        end
        if (!entries[idx].dispatched && !entries[idx].complete) begin
          older_open = 1'b1;
        end
      end
    end

    // Youngest older store to the load address, later match overrides
    for (int k = 0; k < `LSU_QUEUE_DEPTH; k++) begin
      idx = head + (`LSU_PTR_W)'(k);
      if (ld_ok && ((`LSU_PTR_W)'(k) < ld_age) && entries[idx].valid &&
          (entries[idx].op == lsu_pkg::LSU_STORE) &&
          (entries[idx].addr == entries[ld_idx].addr)) begin
        hit       = 1'b1;
        hit_value = entries[idx].value;
      end
    end

    // --------------------
    // Outputs
    // --------------------
    fwd.valid = ld_ok && hit;
    fwd.idx   = ld_idx;
    fwd.value = hit_value;

    // Older of the memory load and the head-of-line store
    use_ld     = ld_ok && !hit && (ld_first || !st_ok);
    use_st     = st_ok && !use_ld;
    sel        = use_ld ? ld_idx : st_idx;
    cand_idx   = sel;
    cand.valid = use_ld || use_st;
    cand.we    = use_st;
    cand.tag   = entries[sel].tag;
    cand.addr  = entries[sel].addr;
    cand.value = entries[sel].value;
  end

endmodule

// ==== src/lsu_mem_port.sv ====
`timescale 1ns/1ps

module lsu_mem_port (
  input  logic                   clk_in,
  input  logic                   rst_N_in,
  input  lsu_pkg::lsu_mem_req_t  cand,
  output logic                   take,
  output lsu_pkg::lsu_mem_req_t  l1d_req,
  input  logic                   l1d_ready,
  input  lsu_pkg::lsu_mem_resp_t l1d_resp,
  output lsu_pkg::lsu_mem_resp_t mem_resp
);

  // Single outstanding access
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    WAIT
  } state_e;

  state_e                state_q;
  lsu_pkg::lsu_mem_req_t req_q;

  // Only free when nothing is in flight
  assign take    = (state_q == IDLE) && cand.valid;
  assign l1d_req = req_q;

  // --------------------
  // Response filter
  // --------------------
  always_comb begin
    mem_resp        = l1d_resp;
    // Stray tags are dropped, only our own request counts
    mem_resp.strobe = (state_q == WAIT) && l1d_resp.strobe &&
                      (l1d_resp.tag == req_q.tag);
  end

  // --------------------
  // Request FSM
  // --------------------
  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      state_q     <= IDLE;
      req_q.valid <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          // Candidate arrives with valid set
          if (take) begin
            req_q   <= cand;
            state_q <= REQ;
          end
        end
        REQ: begin
          // Hold fields until the cache accepts
          if (l1d_ready) begin
            req_q.valid <= 1'b0;
            state_q     <= WAIT;
          end
        end
        WAIT: begin
          if (mem_resp.strobe) begin
            state_q <= IDLE;
          end
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

endmodule

// ==== src/lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_top (
  input  logic                   clk_in,
  input  logic                   rst_N_in,
  input  lsu_pkg::lsu_instr_t    instr,
  output logic                   instr_ready,
  input  lsu_pkg::lsu_data_t     data,
  output lsu_pkg::lsu_mem_req_t  l1d_req,
  input  logic                   l1d_ready,
  input  lsu_pkg::lsu_mem_resp_t l1d_resp,
  output lsu_pkg::lsu_cpl_t      cpl
);

  // Queue state seen by select
  lsu_pkg::lsu_entry_t    entries [`LSU_QUEUE_DEPTH];
  logic [`LSU_PTR_W-1:0]  head;
  // Select results
  lsu_pkg::lsu_mem_req_t  cand;
  logic [`LSU_PTR_W-1:0]  cand_idx;
  lsu_pkg::lsu_fwd_t      fwd;
  // Port handshake back into the queue
  logic                   take;
  lsu_pkg::lsu_mem_resp_t mem_resp;

  lsu_queue u_queue (
    .clk_in      (clk_in),
    .rst_N_in    (rst_N_in),
    .instr       (instr),
    .data        (data),
    .instr_ready (instr_ready),
    .entries     (entries),
    .head        (head),
    .cand_idx    (cand_idx),
    .take        (take),
    .fwd         (fwd),
    .mem_resp    (mem_resp),
    .cpl         (cpl)
  );

  lsu_dispatch_select u_select (
    .entries  (entries),
    .head     (head),
    .cand     (cand),
    .cand_idx (cand_idx),
    .fwd      (fwd)
  );

  lsu_mem_port u_mem_port (
    .clk_in    (clk_in),
    .rst_N_in  (rst_N_in),
    .cand      (cand),
    .take      (take),
    .l1d_req   (l1d_req),
    .l1d_ready (l1d_ready),
    .l1d_resp  (l1d_resp),
    .mem_resp  (mem_resp)
  );

endmodule

// ==== dv/lsu_props.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_props (
  input logic                   clk_in,
  input logic                   rst_N_in,
  input lsu_pkg::lsu_mem_req_t  l1d_req,
  input logic                   l1d_ready,
  input lsu_pkg::lsu_mem_resp_t l1d_resp,
  input lsu_pkg::lsu_cpl_t      cpl
);

  // Set from acceptance until the matching response
  logic outstanding;

  always_ff @(posedge clk_in) begin
    if (!rst_N_in) begin
      outstanding <= 1'b0;
    end else if (l1d_req.valid && l1d_ready) begin
      outstanding <= 1'b1;
    end else if (l1d_resp.strobe) begin
      outstanding <= 1'b0;
    end
  end

  // --------------------
  // L1D request side
  // --------------------
  // Stalled request keeps valid and every field
  req_held: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    (l1d_req.valid && !l1d_ready) |=> (l1d_req.valid && $stable(l1d_req)))
    else $error("L1D request dropped or changed before acceptance");

  // No second request while one is in flight
  one_outstanding: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    outstanding |-> !l1d_req.valid)
    else $error("L1D request raised while another is outstanding");

  // Completion follows each response by one cycle
  resp_to_cpl: assert property (@(posedge clk_in) disable iff (!rst_N_in)
    l1d_resp.strobe |=> cpl.strobe)
    else $error("No completion one cycle after an L1D response");

endmodule

bind lsu_top lsu_props u_props (
  .clk_in    (clk_in),
  .rst_N_in  (rst_N_in),
  .l1d_req   (l1d_req),
  .l1d_ready (l1d_ready),
  .l1d_resp  (l1d_resp),
  .cpl       (cpl)
);

// ==== dv/lsu_tb.sv ====
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_tb;

  localparam int NUM_OPS = 200;
  localparam int STIM_LIMIT = 20000;
  localparam int DRAIN_LIMIT = 2000;

  logic                   clk_in;
  logic                   rst_N_in;
  lsu_pkg::lsu_instr_t    instr;
  logic                   instr_ready;
  lsu_pkg::lsu_data_t     data;
  lsu_pkg::lsu_mem_req_t  l1d_req;
  logic                   l1d_ready;
  lsu_pkg::lsu_mem_resp_t l1d_resp;
  lsu_pkg::lsu_cpl_t      cpl;

  logic [31:0] lfsr;
  int          err_count;
  int          timeout_count;
  int          fwd_count;
  bit          running;

  // Per-tag view of the program
  bit          is_store [256];
  bit          has_older_st [256];
  bit          done [256];
  bit          req_seen [256];
  logic [63:0] addr_of [256];
  logic [63:0] value_of [256];
  logic [63:0] expect_of [256];
  // Latest store value per address, in program order
  logic [63:0] shadow [logic [63:0]];
  // L1D contents, written on store acceptance
  logic [63:0] mem_arr [logic [63:0]];
  logic [7:0]  st_order [$];
  logic [7:0]  pending [$];
  // Allocated and not yet retired, in program order
  logic [7:0]  order_q [$];

  lsu_top dut (
    .clk_in      (clk_in),
    .rst_N_in    (rst_N_in),
    .instr       (instr),
    .instr_ready (instr_ready),
    .data        (data),
    .l1d_req     (l1d_req),
    .l1d_ready   (l1d_ready),
    .l1d_resp    (l1d_resp),
    .cpl         (cpl)
  );

  initial begin
    clk_in = 1'b0;
    forever #20 clk_in = ~clk_in;
  end

  // --------------------
  // Helpers
  // --------------------
  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      r    = {r[62:0], lfsr[0]};
    end
    return r;
  endfunction

  // Reset contents, every address bit matters
  function automatic logic [63:0] init_word(input logic [63:0] a);
    return {a[31:0], ~a[31:0]} ^ {a[63:32], a[63:32]} ^ 64'hA5C3_0F96_5A3C_F069;
  endfunction

  function automatic logic [63:0] mem_read(input logic [63:0] a);
    return mem_arr.exists(a) ? mem_arr[a] : init_word(a);
  endfunction

  task automatic wait_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      @(posedge clk_in);
      #2;
    end
  endtask

  // --------------------
  // L1D model
  // --------------------
  task automatic serve_request();
    lsu_pkg::lsu_mem_req_t req;
    bit                    st_open;
    wait_cycles(int'(rand_bits(2)));
    l1d_ready = 1'b1;
    req = l1d_req;
    @(posedge clk_in);
    #2;
    l1d_ready = 1'b0;
    req_seen[req.tag] = 1'b1;
    if (req.we) begin
      // Stores leave in program order with their own address and data
      assert (st_order.size() > 0 && st_order[0] == req.tag) else begin
        err_count++;
        $display("Fail %0t: store tag %0d reached L1D out of order", $time, req.tag);
      end
      assert (req.addr == addr_of[req.tag] && req.value == value_of[req.tag]) else begin
        err_count++;
        $display("Fail %0t: store tag %0d has wrong address or data", $time, req.tag);
      end
      if (st_order.size() > 0) st_order.pop_front();
      mem_arr[req.addr] = req.value;
    end else begin
      // Older store to this address still live, the load had to forward
      st_open = 1'b0;
      for (int j = 0; j < int'(req.tag); j++) begin
        if (is_store[j] && !done[j] && addr_of[j] == req.addr) begin
          st_open = 1'b1;
        end
      end
      assert (!st_open) else begin
        err_count++;
        $display("Fail %0t: load tag %0d went to L1D despite an older store", $time,
                 req.tag);
      end
    end
    wait_cycles(int'(rand_bits(2)));
    l1d_resp.strobe         = 1'b1;
    l1d_resp.tag            = req.tag;
    l1d_resp.write_complete = req.we;
    l1d_resp.value          = req.we ? '0 : mem_read(req.addr);
    @(posedge clk_in);
    #2;
    l1d_resp.strobe = 1'b0;
  endtask

  initial begin
    wait_cycles(6);
    while (running) begin
      @(posedge clk_in);
      #2;
      if (l1d_req.valid) serve_request();
    end
  end

  // --------------------
  // Completion monitor
  // --------------------
  always @(negedge clk_in) begin
    if (rst_N_in) begin
      // Full while eight entries are still unretired
      assert (instr_ready == (order_q.size() != `LSU_QUEUE_DEPTH)) else begin
        err_count++;
        $display("Fail %0t: instr_ready %0b with %0d live entries", $time, instr_ready,
                 order_q.size());
      end
      if (cpl.strobe) begin
        assert (!done[cpl.tag]) else begin
          err_count++;
          $display("Fail %0t: tag %0d completed twice", $time, cpl.tag);
        end
        done[cpl.tag] = 1'b1;
        if (is_store[cpl.tag]) begin
          assert (cpl.value == '0) else begin
            err_count++;
            $display("Fail %0t: store tag %0d completed with nonzero value", $time, cpl.tag);
          end
        end else begin
          assert (cpl.value == expect_of[cpl.tag]) else begin
            err_count++;
            $display("Fail %0t: load tag %0d got %h, expected %h", $time, cpl.tag,
                     cpl.value, expect_of[cpl.tag]);
          end
          // Without an L1D request the value must come from an older store
          if (!req_seen[cpl.tag]) begin
            fwd_count++;
            assert (has_older_st[cpl.tag]) else begin
              err_count++;
              $display("Fail %0t: load tag %0d forwarded with no older store", $time,
                       cpl.tag);
            end
          end
        end
      end
      // Head steps over one freed entry per cycle
      if (order_q.size() > 0 && done[order_q[0]]) order_q.pop_front();
      if (instr.strobe && instr_ready) order_q.push_back(instr.tag);
    end
  end

  // --------------------
  // Stimulus
  // --------------------
  initial begin
    int          issued;
    int          cycles;
    int          idx;
    bit          issued_last;
    logic [63:0] a;
    logic [7:0]  t;

    lfsr      = 32'h5f5b_12a1;
    err_count = 0;
    timeout_count = 0;
    fwd_count = 0;
    running   = 1'b1;
    rst_N_in  = 1'b0;
    instr     = '0;
    data      = '0;
    l1d_ready = 1'b0;
    l1d_resp  = '0;
    issued      = 0;
    cycles      = 0;
    issued_last = 1'b0;
    wait_cycles(5);
    rst_N_in = 1'b1;

    while (issued < NUM_OPS || pending.size() > 0 || issued_last) begin
      @(posedge clk_in);
      #2;
      cycles++;
      if (cycles > STIM_LIMIT) begin
        timeout_count++;
        $display("Timeout: stimulus did not finish issuing and resolving ops");
        break;
      end
      // Allocated at the edge just passed, data may follow now
      if (issued_last) pending.push_back(instr.tag);
      issued_last  = 1'b0;
      instr.strobe = 1'b0;
      data.strobe  = 1'b0;
      if (issued < NUM_OPS && instr_ready && rand_bits(1)) begin
        t = 8'(issued);
        a = 64'h1000 + 64'(rand_bits(2)) * 8;
        is_store[t] = 1'(rand_bits(1));
        addr_of[t]  = a;
        value_of[t] = rand_bits(64);
        if (is_store[t]) begin
          shadow[a] = value_of[t];
          st_order.push_back(t);
        end else begin
          has_older_st[t] = shadow.exists(a) != 0;
          expect_of[t]    = shadow.exists(a) ? shadow[a] : init_word(a);
        end
        instr.strobe = 1'b1;
        instr.tag    = t;
        instr.op     = is_store[t] ? lsu_pkg::LSU_STORE : lsu_pkg::LSU_LOAD;
        issued++;
        issued_last = 1'b1;
      end
      // Deliver some pending tag, order scrambled
      if (pending.size() > 0 && rand_bits(1)) begin
        idx = int'(rand_bits(3)) % pending.size();
        t   = pending[idx];
        pending.delete(idx);
        data.strobe = 1'b1;
        data.tag    = t;
        data.addr   = addr_of[t];
        data.value  = is_store[t] ? value_of[t] : '0;
      end
    end
    @(posedge clk_in);
    #2;
    instr.strobe = 1'b0;
    data.strobe  = 1'b0;

    // Drain until every tag has completed
    cycles = 0;
    while (1) begin
      idx = 0;
      for (int i = 0; i < NUM_OPS; i++) if (!done[i]) idx++;
      if (idx == 0) break;
      if (cycles > DRAIN_LIMIT) begin
        timeout_count++;
        $display("Timeout: %0d tags never completed", idx);
        break;
      end
      wait_cycles(1);
      cycles++;
    end
    running = 1'b0;
    wait_cycles(10);

    assert (fwd_count > 0) else begin
      err_count++;
      $display("Fail %0t: no load was forwarded", $time);
    end

    $display("Errors: %0d check failures, %0d timeouts, %0d forwarded loads", err_count,
             timeout_count, fwd_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+src
src/lsu_pkg.sv
src/lsu_queue.sv
src/lsu_dispatch_select.sv
src/lsu_mem_port.sv
src/lsu_top.sv
dv/lsu_props.sv
dv/lsu_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= lsu_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
